// ==== build.f ====
+incdir+include
rtl/mmioPkg.sv
rtl/emifBusPort.sv
rtl/regBank.sv
rtl/fieldMap.sv
rtl/mmioClient.sv
bench/mmioClientTb.sv

// ==== include/mmioBusTasks.svh ====
// ----------------------------------------------------------------------
// PSoC bus access tasks for the MMIO client testbench
// Writes of one or more cycles, and reads that wait for the data
// enable with a timeout
// ----------------------------------------------------------------------
`ifndef MMIO_BUS_TASKS_SVH
`define MMIO_BUS_TASKS_SVH

localparam int busTimeout = 8;   // Cycles allowed for read data

// Write held for holdCycles, data changes after the first cycle
task automatic busWrite(input logic [7:0] addr, input busDataT data,
                        input int holdCycles = 1);
  @(negedge shlClk);
  busAddr   = addr;
  busDataIn = data;
  busCsN    = 1'b0;
  busWeN    = 1'b0;
  for (int i = 1; i < holdCycles; i++)
  begin
    @(negedge shlClk);
    busDataIn = ~data ^ busDataT'(i);  // Must not reach the register
  end
  @(negedge shlClk);
  busCsN = 1'b1;
  busWeN = 1'b1;
  @(negedge shlClk);                   // Idle cycle, register now updated
endtask

task automatic busRead(input logic [7:0] addr, output busDataT data);
  int cycles;
  @(negedge shlClk);
  busAddr = addr;
  busCsN  = 1'b0;
  busOeN  = 1'b0;
  @(negedge shlClk);                   // Sampled on the edge just passed
  busCsN = 1'b1;
  busOeN = 1'b1;
  cycles = 0;
  while (!busDataEn && cycles < busTimeout)
  begin
    @(negedge shlClk);
    cycles++;
  end
  data = busDataOut;
  if (!busDataEn)
  begin
    errCount++;
    $display("Read of address 0x%02h timed out, data enable never rose", addr);
  end
  else
    checkValue("read latency (cycles)", cycles, 1);
endtask

`endif

// ==== bench/mmioClientTb.sv ====
// ----------------------------------------------------------------------
// MMIO client testbench
// Drives the PSoC bus and status inputs, checks readback and control
// outputs against a byte model of the register map
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mmioClientTb;

  import mmioPkg::*;

  localparam int          mapBytes  = bankCount * bankBytes;
  localparam int unsigned randSeed  = 32'h00cb_8ef9;
  localparam busDataT     dateYear  = 8'h18;
  localparam busDataT     dateMonth = 8'h0B;
  localparam busDataT     dateDay   = 8'h14;

  logic       shlClk;
  logic       reset;
  logic       busCsN;
  logic       busWeN;
  logic       busOeN;
  logic [7:0] busAddr;
  busDataT    busDataIn;
  busDataT    busDataOut;
  logic       busDataEn;
  logic       mc0InitCalComplete;
  logic       mc1InitCalComplete;
  logic       eth0CoreReady;
  logic       eth0QpllLock;
  roleRegT    roleRegIn;
  logic       eth0RxEqualizerMode;
  logic [3:0] eth0TxDriverSwing;
  logic [4:0] eth0TxPreCursor;
  logic [4:0] eth0TxPostCursor;
  logic       eth0PcsLoopbackEn;
  logic       eth0MacLoopbackEn;
  logic       eth0MacAddrSwapEn;
  macAddrT    nts0MacAddress;
  ipAddrT     nts0IpAddress;
  logic [1:0] roleUdpEchoCtrl;
  logic       roleUdpPostPktEn;
  logic       roleUdpCaptPktEn;
  logic [1:0] roleTcpEchoCtrl;
  logic       roleTcpPostPktEn;
  logic       roleTcpCaptPktEn;
  roleRegT    roleRegOut;

  int      errCount   = 0;
  int      checkCount = 0;
  busDataT defImg    [mapBytes];   // Reset value of every byte
  busDataT wrMask    [mapBytes];
  busDataT stored    [mapBytes];   // Writable bits as last written
  busDataT statusMem [mapBytes];   // Live status driven by the bench
  busDataT d;
  int      a;

  mmioClient #(
    .topDateYear  (dateYear),
    .topDateMonth (dateMonth),
    .topDateDay   (dateDay)
  ) DUT (.*);

  initial
  begin
    shlClk = 1'b0;
    forever #2 shlClk = ~shlClk;   // 4 ns period
  end

  task automatic checkValue(input string name, input logic [47:0] actual,
                            input logic [47:0] expected);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errCount++;
      $display("CHECK FAILED at %0t: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  `include "mmioBusTasks.svh"

  // Data enable follows chip select and output enable by two edges
  assert property (@(posedge shlClk) disable iff (reset)
    busDataEn == $past(!busCsN && !busOeN, 2))
  else
  begin
    errCount++;
    $display("CHECK FAILED at %0t: busDataEn expected %0b actual %0b",
             $time, !$sampled(busDataEn), $sampled(busDataEn));
  end

  // ----------------------------------------------------------------------
  // Reference byte model
  // ----------------------------------------------------------------------
  function automatic busDataT expectedByte(input int adr);
    return (stored[adr] & wrMask[adr]) | ((defImg[adr] | statusMem[adr]) & ~wrMask[adr]);
  endfunction

  task automatic modelWrite(input int adr, input busDataT data);
    stored[adr] = (stored[adr] & ~wrMask[adr]) | (data & wrMask[adr]);
  endtask

  task automatic checkControls();
    checkValue("eth0RxEqualizerMode", eth0RxEqualizerMode, stored['h11][0]);
    checkValue("eth0TxDriverSwing", eth0TxDriverSwing, stored['h11][7:4]);
    checkValue("eth0TxPreCursor", eth0TxPreCursor, stored['h12][4:0]);
    checkValue("eth0TxPostCursor", eth0TxPostCursor, stored['h13][4:0]);
    checkValue("nts0MacAddress", nts0MacAddress, {stored['h27], stored['h26],
               stored['h25], stored['h24], stored['h23], stored['h22]});
    checkValue("nts0IpAddress", nts0IpAddress,
               {stored['h37], stored['h36], stored['h35], stored['h34]});
    checkValue("roleRegOut", roleRegOut, {stored['h43], stored['h42]});
    checkValue("eth0PcsLoopbackEn", eth0PcsLoopbackEn, stored['h74][0]);
    checkValue("eth0MacLoopbackEn", eth0MacLoopbackEn, stored['h74][1]);
    checkValue("eth0MacAddrSwapEn", eth0MacAddrSwapEn, stored['h74][2]);
    checkValue("roleUdpEchoCtrl", roleUdpEchoCtrl, stored['h76][1:0]);
    checkValue("roleUdpPostPktEn", roleUdpPostPktEn, stored['h76][2]);
    checkValue("roleUdpCaptPktEn", roleUdpCaptPktEn, stored['h76][3]);
    checkValue("roleTcpEchoCtrl", roleTcpEchoCtrl, stored['h76][5:4]);
    checkValue("roleTcpPostPktEn", roleTcpPostPktEn, stored['h76][6]);
    checkValue("roleTcpCaptPktEn", roleTcpCaptPktEn, stored['h76][7]);
  endtask

  task automatic readCheck(input logic [7:0] addr, input busDataT expected);
    busDataT data;
    busRead(addr, data);
    checkValue($sformatf("busDataOut at 0x%02h", addr), data, expected);
  endtask

  task automatic readSweep();
    for (int i = 0; i < mapBytes; i++)
      readCheck(8'(i), expectedByte(i));
  endtask

  // New random status, bits 0 to 3 of 0x10 and role word at 0x40
  task automatic driveStatus();
    logic [3:0] st;
    roleRegT    role;
    st   = 4'($urandom);
    role = roleRegT'($urandom);
    @(negedge shlClk);
    {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = st;
    roleRegIn        = role;
    statusMem['h10]  = {4'h0, st};
    statusMem['h40]  = role[7:0];
    statusMem['h41]  = role[15:8];
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial
  begin
    void'($urandom(randSeed));
    reset = 1'b1;
    {busCsN, busWeN, busOeN} = 3'b111;   // Bus idle
    busAddr   = '0;
    busDataIn = '0;
    {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = 4'h0;
    roleRegIn = '0;
    for (int i = 0; i < mapBytes; i++)
    begin
      defImg[i]    = mmioDefaultImage[8*i +: 8];
      wrMask[i]    = mmioWriteMask[8*i +: 8];
      statusMem[i] = '0;
    end
    defImg[5] = dateYear;                // Date bytes come from the top level
    defImg[6] = dateMonth;
    defImg[7] = dateDay;
    stored    = defImg;
    repeat (8) @(posedge shlClk);
    @(negedge shlClk);
    reset = 1'b0;

    // Reset image and default control fields
    checkValue("busDataEn", busDataEn, 1'b0);
    checkControls();
    readSweep();

    // Random write to every byte, then immediate readback
    for (int i = 0; i < mapBytes; i++)
    begin
      d = busDataT'($urandom);
      busWrite(8'(i), d);
      modelWrite(i, d);
      checkControls();
      readCheck(8'(i), expectedByte(i));
    end
    readSweep();

    // Live status readback
    repeat (8)
    begin
      driveStatus();
      readCheck(8'h10, expectedByte('h10));
      readCheck(8'h40, expectedByte('h40));
      readCheck(8'h41, expectedByte('h41));
    end

    // Held writes keep the first cycle's data
    for (int k = 0; k < 3; k++)
    begin
      a = (k == 0) ? 'h36 : (k == 1) ? 'h42 : 'h76;
      d = busDataT'($urandom);
      busWrite(8'(a), d, 4);
      modelWrite(a, d);
      checkControls();
      readCheck(8'(a), expectedByte(a));
    end

    // Upper half reads zero and ignores writes
    repeat (16)
    begin
      a = int'($urandom_range(mapBytes - 1));
      busWrite(8'h80 | 8'(a), busDataT'($urandom));
      readCheck(8'h80 | 8'(a), 8'h00);
    end
    checkControls();
    readSweep();

    $display("Checks run: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/mmioClient.sv ====
// ----------------------------------------------------------------------
// MMIO client
// Control and status register file of 128 bytes on the PSoC bus,
// built from a bus port, eight register banks and a field map
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mmioClient #(
  parameter mmioPkg::busDataT topDateYear  = 8'hFF,
  parameter mmioPkg::busDataT topDateMonth = 8'hFF,
  parameter mmioPkg::busDataT topDateDay   = 8'hFF
) (
  input  wire logic                           shlClk,
  input  wire logic                           reset,
  // PSoC bus
  input  wire logic                           busCsN,
  input  wire logic                           busWeN,
  input  wire logic                           busOeN,
  input  wire logic [mmioPkg::busAddrWidth:0] busAddr,
  input  wire mmioPkg::busDataT               busDataIn,
  output mmioPkg::busDataT                    busDataOut,
  output logic                                busDataEn,
  // Status
  input  wire logic                           mc0InitCalComplete,
  input  wire logic                           mc1InitCalComplete,
  input  wire logic                           eth0CoreReady,
  input  wire logic                           eth0QpllLock,
  input  wire mmioPkg::roleRegT               roleRegIn,
  // Control
  output logic                                eth0RxEqualizerMode,
  output logic [3:0]                          eth0TxDriverSwing,
  output logic [4:0]                          eth0TxPreCursor,
  output logic [4:0]                          eth0TxPostCursor,
  output logic                                eth0PcsLoopbackEn,
  output logic                                eth0MacLoopbackEn,
  output logic                                eth0MacAddrSwapEn,
  output mmioPkg::macAddrT                    nts0MacAddress,
  output mmioPkg::ipAddrT                     nts0IpAddress,
  output logic [1:0]                          roleUdpEchoCtrl,
  output logic                                roleUdpPostPktEn,
  output logic                                roleUdpCaptPktEn,
  output logic [1:0]                          roleTcpEchoCtrl,
  output logic                                roleTcpPostPktEn,
  output logic                                roleTcpCaptPktEn,
  output mmioPkg::roleRegT                    roleRegOut
);

  import mmioPkg::*;

  // Build date goes into bytes 5 to 7 of the configuration bank
  localparam logic [mmioBits-1:0] dateImage =
    mmioBits'({topDateDay, topDateMonth, topDateYear}) << (8 * cfgTopYear);
  localparam logic [mmioBits-1:0] fullDefault = mmioDefaultImage | dateImage;

  logic       wrStrobe;
  bankSelT    wrBank;
  byteOffsetT wrOffset;
  byteOffsetT rdOffset;
  busDataT    wrData;
  busDataT    rdByte      [bankCount];
  bankImageT  bankImage   [bankCount];
  bankImageT  statusImage [bankCount];

  emifBusPort uBusPort (
    .shlClk     (shlClk),
    .reset      (reset),
    .busCsN     (busCsN),
    .busWeN     (busWeN),
    .busOeN     (busOeN),
    .busAddr    (busAddr),
    .busDataIn  (busDataIn),
    .rdByte     (rdByte),
    .wrStrobe   (wrStrobe),
    .wrBank     (wrBank),
    .wrOffset   (wrOffset),
    .rdOffset   (rdOffset),
    .wrData     (wrData),
    .busDataOut (busDataOut),
    .busDataEn  (busDataEn)
  );

  // ----------------------------------------------------------------------
  // Register banks, each with its slice of the image and mask
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < bankCount; i++)
  begin : genBank
    regBank #(
      .bankIndex     (i),
      .bankDefault   (fullDefault[i*bankBits +: bankBits]),
      .bankWriteMask (mmioWriteMask[i*bankBits +: bankBits])
    ) uBank (
      .shlClk      (shlClk),
      .reset       (reset),
      .wrStrobe    (wrStrobe),
      .wrBank      (wrBank),
      .wrOffset    (wrOffset),
      .rdOffset    (rdOffset),
      .wrData      (wrData),
      .statusImage (statusImage[i]),
      .bankImage   (bankImage[i]),
      .rdByte      (rdByte[i])
    );
  end

  fieldMap uFieldMap (
    .bankImage           (bankImage),
    .mc0InitCalComplete  (mc0InitCalComplete),
    .mc1InitCalComplete  (mc1InitCalComplete),
    .eth0CoreReady       (eth0CoreReady),
    .eth0QpllLock        (eth0QpllLock),
    .roleRegIn           (roleRegIn),
    .statusImage         (statusImage),
    .eth0RxEqualizerMode (eth0RxEqualizerMode),
    .eth0TxDriverSwing   (eth0TxDriverSwing),
    .eth0TxPreCursor     (eth0TxPreCursor),
    .eth0TxPostCursor    (eth0TxPostCursor),
    .eth0PcsLoopbackEn   (eth0PcsLoopbackEn),
    .eth0MacLoopbackEn   (eth0MacLoopbackEn),
    .eth0MacAddrSwapEn   (eth0MacAddrSwapEn),
    .nts0MacAddress      (nts0MacAddress),
    .nts0IpAddress       (nts0IpAddress),
    .roleUdpEchoCtrl     (roleUdpEchoCtrl),
    .roleUdpPostPktEn    (roleUdpPostPktEn),
    .roleUdpCaptPktEn    (roleUdpCaptPktEn),
    .roleTcpEchoCtrl     (roleTcpEchoCtrl),
    .roleTcpPostPktEn    (roleTcpPostPktEn),
    .roleTcpCaptPktEn    (roleTcpCaptPktEn),
    .roleRegOut          (roleRegOut)
  );

endmodule

`default_nettype wire

// ==== rtl/fieldMap.sv ====
// ----------------------------------------------------------------------
// Field map of the MMIO register file
// Slices the bank images into named control outputs and gathers the
// status inputs into per-bank status images
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fieldMap (
  input  wire mmioPkg::bankImageT bankImage [mmioPkg::bankCount],
  input  wire logic               mc0InitCalComplete,
  input  wire logic               mc1InitCalComplete,
  input  wire logic               eth0CoreReady,
  input  wire logic               eth0QpllLock,
  input  wire mmioPkg::roleRegT   roleRegIn,
  output mmioPkg::bankImageT      statusImage [mmioPkg::bankCount],
  output logic                    eth0RxEqualizerMode,
  output logic [3:0]              eth0TxDriverSwing,
  output logic [4:0]              eth0TxPreCursor,
  output logic [4:0]              eth0TxPostCursor,
  output logic                    eth0PcsLoopbackEn,
  output logic                    eth0MacLoopbackEn,
  output logic                    eth0MacAddrSwapEn,
  output mmioPkg::macAddrT        nts0MacAddress,
  output mmioPkg::ipAddrT         nts0IpAddress,
  output logic [1:0]              roleUdpEchoCtrl,
  output logic                    roleUdpPostPktEn,
  output logic                    roleUdpCaptPktEn,
  output logic [1:0]              roleTcpEchoCtrl,
  output logic                    roleTcpPostPktEn,
  output logic                    roleTcpCaptPktEn,
  output mmioPkg::roleRegT        roleRegOut
);

  import mmioPkg::*;

  logic [mmioBits-1:0] ctrlFlat;   // All banks, byte k at 8k
  logic [mmioBits-1:0] statFlat;

  for (genvar i = 0; i < bankCount; i++)
  begin : genFlat
    assign ctrlFlat[i*bankBits +: bankBits] = bankImage[i];
    assign statusImage[i] = statFlat[i*bankBits +: bankBits];
  end

  // ----------------------------------------------------------------------
  // Status gathering
  // ----------------------------------------------------------------------
  always_comb
  begin
    statFlat = '0;   // Everything else reads its default
    statFlat[8*phyStat +: 4] = {eth0QpllLock, eth0CoreReady,
                                mc1InitCalComplete, mc0InitCalComplete};
    statFlat[8*roleRegInAdr +: 16] = roleRegIn;
  end

  // ----------------------------------------------------------------------
  // Control slices
  // ----------------------------------------------------------------------
  // Transceiver tuning
  assign eth0RxEqualizerMode = ctrlFlat[8*phyEth0];
  assign eth0TxDriverSwing   = ctrlFlat[8*phyEth0+4 +: 4];
  assign eth0TxPreCursor     = ctrlFlat[8*phyEth0Pre +: 5];
  assign eth0TxPostCursor    = ctrlFlat[8*phyEth0Post +: 5];

  assign nts0MacAddress = ctrlFlat[8*ly2Mac0 +: 48];    // Low byte first
  assign nts0IpAddress  = ctrlFlat[8*ly3Ip0 +: 32];
  assign roleRegOut     = ctrlFlat[8*roleRegOutAdr +: 16];

  // Loopback
  assign eth0PcsLoopbackEn = ctrlFlat[8*diagCtrl1+0];
  assign eth0MacLoopbackEn = ctrlFlat[8*diagCtrl1+1];
  assign eth0MacAddrSwapEn = ctrlFlat[8*diagCtrl1+2];

  // UDP test in the low nibble, TCP in the high one
  assign roleUdpEchoCtrl  = ctrlFlat[8*diagCtrl2+0 +: 2];
  assign roleUdpPostPktEn = ctrlFlat[8*diagCtrl2+2];
  assign roleUdpCaptPktEn = ctrlFlat[8*diagCtrl2+3];
  assign roleTcpEchoCtrl  = ctrlFlat[8*diagCtrl2+4 +: 2];
  assign roleTcpPostPktEn = ctrlFlat[8*diagCtrl2+6];
  assign roleTcpCaptPktEn = ctrlFlat[8*diagCtrl2+7];

endmodule

`default_nettype wire

// ==== rtl/regBank.sv ====
// ----------------------------------------------------------------------
// Register bank of 16 bytes
// Writable bits load from the bus under mask, read-only bits return
// their default ORed with a registered status image
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module regBank #(
  parameter int                 bankIndex     = 0,
  parameter mmioPkg::bankImageT bankDefault   = '0,
  parameter mmioPkg::bankImageT bankWriteMask = '0
) (
  input  wire logic                shlClk,
  input  wire logic                reset,
  input  wire logic                wrStrobe,
  input  wire mmioPkg::bankSelT    wrBank,
  input  wire mmioPkg::byteOffsetT wrOffset,
  input  wire mmioPkg::byteOffsetT rdOffset,
  input  wire mmioPkg::busDataT    wrData,
  input  wire mmioPkg::bankImageT  statusImage,
  output mmioPkg::bankImageT       bankImage,
  output mmioPkg::busDataT         rdByte
);

  import mmioPkg::*;

  bankImageT ctrlQ;      // Control bits, read-only ones stay at default
  bankImageT statusQ;    // Status inputs, one stage
  bankImageT readImage;
  busDataT   byteMask;   // Writable bits of the addressed byte
  logic      bankHit;

  assign bankHit  = wrStrobe && (wrBank == bankSelT'(bankIndex));
  assign byteMask = bankWriteMask[8*wrOffset +: 8];

  always_ff @(posedge shlClk)
  begin
    if (reset)
      ctrlQ <= bankDefault;
    else if (bankHit)
      ctrlQ[8*wrOffset +: 8] <= (ctrlQ[8*wrOffset +: 8] & ~byteMask)
                              | (wrData & byteMask);
  end

  always_ff @(posedge shlClk)
  begin
    statusQ <= statusImage;
  end

  // Stored value where writable, default OR status elsewhere
  assign readImage = (ctrlQ & bankWriteMask)
                   | ((bankDefault | statusQ) & ~bankWriteMask);

  assign bankImage = ctrlQ;
  assign rdByte    = readImage[8*rdOffset +: 8];

  // Read-only bits hold their reset value for the whole run
  assert property (@(posedge shlClk) disable iff (reset)
    $stable(ctrlQ & ~bankWriteMask));

endmodule

`default_nettype wire

// ==== rtl/emifBusPort.sv ====
// ----------------------------------------------------------------------
// PSoC external-memory bus port
// Decodes write accesses into a single-cycle strobe with registered
// address and data, and returns the addressed byte with one cycle of
// latency on a split data bus
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module emifBusPort (
  input  wire logic                             shlClk,
  input  wire logic                             reset,
  input  wire logic                             busCsN,
  input  wire logic                             busWeN,
  input  wire logic                             busOeN,
  input  wire logic [mmioPkg::busAddrWidth:0]   busAddr,   // Bit 7 is the upper half
  input  wire mmioPkg::busDataT                 busDataIn,
  input  wire mmioPkg::busDataT                 rdByte [mmioPkg::bankCount],
  output logic                                  wrStrobe,
  output mmioPkg::bankSelT                      wrBank,
  output mmioPkg::byteOffsetT                   wrOffset,
  output mmioPkg::byteOffsetT                   rdOffset,
  output mmioPkg::busDataT                      wrData,
  output mmioPkg::busDataT                      busDataOut,
  output logic                                  busDataEn
);

  import mmioPkg::*;

  logic    wrAccess;   // Write cycle to the lower half
  logic    wrPrev;     // Access already strobed
  logic    rdReqQ;     // Chip and output enable sampled
  logic    rdUpperQ;   // Upper half, reads zero
  busAddrT rdAddrQ;

  assign wrAccess = !busCsN && !busWeN && !busAddr[busAddrWidth];

  // ----------------------------------------------------------------------
  // Write path
  // ----------------------------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      wrPrev   <= 1'b0;
      wrStrobe <= 1'b0;
    end
    else
    begin
      wrPrev   <= wrAccess;
      wrStrobe <= wrAccess && !wrPrev;  // First cycle only
    end
  end

  // Address and data of the first cycle are held for the banks
  always_ff @(posedge shlClk)
  begin
    if (wrAccess && !wrPrev)
    begin
      wrBank   <= busAddr[busAddrWidth-1:offsetBits];
      wrOffset <= busAddr[offsetBits-1:0];
      wrData   <= busDataIn;
    end
  end

  // ----------------------------------------------------------------------
  // Read path
  // ----------------------------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    rdAddrQ  <= busAddr[busAddrWidth-1:0];
    rdUpperQ <= busAddr[busAddrWidth];
  end

  assign rdOffset = rdAddrQ[offsetBits-1:0];  // Same offset to every bank

  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      rdReqQ     <= 1'b0;
      busDataEn  <= 1'b0;
      busDataOut <= '0;
    end
    else
    begin
      rdReqQ    <= !busCsN && !busOeN;
      busDataEn <= rdReqQ;
      if (rdReqQ && !rdUpperQ)
        busDataOut <= rdByte[rdAddrQ[busAddrWidth-1:offsetBits]];
      else
        busDataOut <= '0;
    end
  end

  // One strobe per access while the chip select is held
  assert property (@(posedge shlClk) disable iff (reset)
    (wrStrobe && !busCsN) |=> (busCsN || !wrStrobe));

endmodule

`default_nettype wire

// ==== rtl/mmioPkg.sv ====
// ----------------------------------------------------------------------
// MMIO client shared definitions
// Bus widths, bank layout, register addresses, reset image and the
// per-bit writable mask of the 128-byte register map
// ----------------------------------------------------------------------
`default_nettype none

package mmioPkg;

  parameter int busAddrWidth = 7;                        // Byte address
  parameter int busDataWidth = 8;                        // Data byte
  parameter int bankCount    = 8;
  parameter int bankBytes    = 16;
  parameter int bankBits     = bankBytes * busDataWidth; // 128
  parameter int offsetBits   = $clog2(bankBytes);
  parameter int mmioBits     = bankCount * bankBits;     // Whole map

  // Burned-in identifiers
  parameter logic [7:0] mmioId       = 8'h3C;
  parameter logic [7:0] mmioVersion  = 8'h01;
  parameter logic [7:0] mmioRevision = 8'h00;
  parameter logic [7:0] topId        = 8'h81;

  typedef logic [busAddrWidth-1:0]              busAddrT;
  typedef logic [busDataWidth-1:0]              busDataT;
  typedef logic [busAddrWidth-offsetBits-1:0]   bankSelT;
  typedef logic [offsetBits-1:0]                byteOffsetT;
  typedef logic [bankBits-1:0]                  bankImageT;
  typedef logic [47:0]                          macAddrT;
  typedef logic [31:0]                          ipAddrT;
  typedef logic [15:0]                          roleRegT;

  // ----------------------------------------------------------------------
  // Register addresses used by the field map
  // ----------------------------------------------------------------------
  parameter int cfgTopYear    = 'h05;  // Date bytes follow at 0x06, 0x07
  parameter int phyStat       = 'h10;  // Memory and Ethernet status
  parameter int phyEth0       = 'h11;  // Equalizer and driver swing
  parameter int phyEth0Pre    = 'h12;
  parameter int phyEth0Post   = 'h13;
  parameter int ly2Mac0       = 'h22;  // MAC low byte
  parameter int ly3Ip0        = 'h34;  // IP low byte
  parameter int roleRegInAdr  = 'h40;  // Role to shell, read only
  parameter int roleRegOutAdr = 'h42;  // Shell to role
  parameter int diagCtrl1     = 'h74;  // Loopback controls
  parameter int diagCtrl2     = 'h76;  // Role test controls

  function automatic logic [mmioBits-1:0] buildDefaultImage();
    logic [mmioBits-1:0] img;
    img = '0;
    img[8*'h00 +: 8] = mmioId;
    img[8*'h01 +: 8] = mmioVersion;
    img[8*'h02 +: 8] = mmioRevision;
    img[8*'h03 +: 8] = 8'h33;
    img[8*'h04 +: 8] = topId;
    img[8*phyEth0 +: 8]     = 8'h41;     // Swing 4, equalizer on
    img[8*phyEth0Pre +: 8]  = 8'h05;
    img[8*phyEth0Post +: 8] = 8'h05;
    img[8*'h70 +: 32] = 32'hEFBEADDE; // Scratch reads DE AD BE EF
    return img;
  endfunction

  function automatic logic [mmioBits-1:0] buildWriteMask();
    logic [mmioBits-1:0] msk;
    msk = '0;
    for (int a = 0; a < bankCount * bankBytes; a++)
    begin
      if (a inside {['h11:'h13], 'h20, ['h22:'h27], 'h30, ['h34:'h37],
                    ['h42:'h43], ['h70:'h74], 'h76})
        msk[8*a +: 8] = 8'hFF;
    end
    return msk;
  endfunction

  parameter logic [mmioBits-1:0] mmioDefaultImage = buildDefaultImage();
  parameter logic [mmioBits-1:0] mmioWriteMask    = buildWriteMask();

endpackage

`default_nettype wire
